//--- all.f
+incdir+tests
verilog/tk_disk_pkg.sv
verilog/sd_xfer_if.sv
verilog/track_sequencer.sv
verilog/sd_block_counter.sv
verilog/track_buffer.sv
verilog/joy_key_merge.sv
verilog/tk_disk_top.sv
tests/sd_host_model.sv
tests/tk_disk_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the floppy track cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tk_disk_tb -f all.f -o tk_disk_sim

out=$(./obj_dir/tk_disk_sim)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"

//--- tests/disk_image.svh
//==============================
// Disk image byte pattern
// Xorshift random generator
//==============================

localparam logic [31:0] RNG_SEED = 32'h6eb5_7015;

// Every byte depends on drive, block and full offset
function automatic logic [7:0] image_byte(input logic drive, input logic [31:0] lba,
                                          input logic [8:0] off);
	logic [7:0] b;
	b = (lba[7:0] * 8'd29) ^ lba[15:8] ^ off[7:0] ^ {off[8], 7'd0};
	b = b ^ (drive ? 8'ha5 : 8'h3c);
	return b;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

//--- tests/sd_host_model.sv
//==============================
// SD block host model
// Streams the disk image, logs
// blocks and captures writes
//==============================

`timescale 1ns/1ns

module sd_host_model (
	input  logic        CLK_VIDEO,
	input  logic        dd_reset,
	input  logic [1:0]  sd_rd_i,
	input  logic [1:0]  sd_wr_i,
	input  logic [31:0] sd_lba_i,
	input  logic [7:0]  sd_buff_din_i,
	output logic [1:0]  sd_ack_o,
	output logic [8:0]  sd_buff_addr_o,
	output logic [7:0]  sd_buff_dout_o,
	output logic        sd_buff_wr_o
);
	`include "disk_image.svh"

	localparam int H_IDLE   = 0;
	localparam int H_GAP    = 1;
	localparam int H_STREAM = 2;

	int          state;
	int          gap;
	int          off;
	logic        drv;
	logic        is_wr;
	logic [31:0] lba;
	logic [31:0] rng;

	// Served blocks in order, read by the testbench
	int          blk_count;
	logic [31:0] blk_lba [0:127];
	logic        blk_drv [0:127];
	logic        blk_wr  [0:127];
	// Bytes taken from the DUT, indexed by block and offset
	logic [7:0]  wr_mem  [0:65535];

	initial begin
		sd_ack_o       = 2'b00;
		sd_buff_addr_o = 9'd0;
		sd_buff_dout_o = 8'd0;
		sd_buff_wr_o   = 1'b0;
	end

	always @(negedge CLK_VIDEO) begin
		if (dd_reset) begin
			state     = H_IDLE;
			rng       = RNG_SEED;
			blk_count = 0;
			sd_ack_o     <= 2'b00;
			sd_buff_wr_o <= 1'b0;
		end else begin
			case (state)
				H_IDLE: begin
					if ((|sd_rd_i) || (|sd_wr_i)) begin
						drv   = sd_rd_i[1] | sd_wr_i[1];
						is_wr = |sd_wr_i;
						rng   = xorshift32(rng);
						gap   = 1 + int'(rng[2:0]);
						state = H_GAP;
					end
				end
				H_GAP: begin
					gap = gap - 1;
					if (gap == 0) begin
						lba                = sd_lba_i;
						blk_lba[blk_count] = lba;
						blk_drv[blk_count] = drv;
						blk_wr[blk_count]  = is_wr;
						blk_count++;
						off = 0;
						sd_ack_o       <= 2'b01 << drv;
						sd_buff_addr_o <= 9'd0;
						sd_buff_dout_o <= image_byte(drv, lba, 9'd0);
						sd_buff_wr_o   <= ~is_wr;
						state = H_STREAM;
					end
				end
				H_STREAM: begin
					// Read data lags the address by one cycle
					if (is_wr) begin
						wr_mem[lba * 512 + off] = sd_buff_din_i;
					end
					off++;
					if (off == 512) begin
						sd_ack_o     <= 2'b00;
						sd_buff_wr_o <= 1'b0;
						state = H_IDLE;
					end else begin
						sd_buff_addr_o <= 9'(off);
						sd_buff_dout_o <= image_byte(drv, lba, 9'(off));
					end
				end
				default: state = H_IDLE;
			endcase
		end
	end

endmodule

//--- tests/tk_disk_tb.sv
//==============================
// Floppy track cache testbench
// Loads, flush, drive select
// and joystick merge checks
//==============================

`timescale 1ns/1ns

module tk_disk_tb;
	`include "disk_image.svh"

	logic        CLK_VIDEO;
	logic        dd_reset;
	logic [1:0]  fd_active;
	logic [5:0]  track0;
	logic [5:0]  track1;
	logic [1:0]  img_mounted;
	logic [31:0] img_size;
	logic [1:0]  sd_ack;
	logic [8:0]  sd_buff_addr;
	logic [7:0]  sd_buff_dout;
	logic        sd_buff_wr;
	logic [13:0] fd_track_addr;
	logic        fd_write;
	logic [7:0]  fd_data;
	logic [5:0]  joy;
	logic [7:0]  kbd_rows;
	logic [5:0]  kbd_cols;
	logic [31:0] sd_lba;
	logic [1:0]  sd_rd;
	logic [1:0]  sd_wr;
	logic [7:0]  sd_buff_din;
	logic [7:0]  fd_rdata;
	logic        cpu_wait;
	logic        led;
	logic [5:0]  kbd_merged;

	int          errors;
	int          err_at_start;
	int          tests_run;
	int          tests_failed;
	logic        timed_out;
	logic [31:0] rng;
	int          first;
	int          wr_off [0:7];
	logic [7:0]  wr_val [0:7];
	logic        req_any;
	logic        ack_q;
	int          ack_count;
	logic [5:0]  exp_cols;

	tk_disk_top tk_disk_top_inst (
		.CLK_VIDEO(CLK_VIDEO), .dd_reset(dd_reset), .fd_active_i(fd_active),
		.track0_i(track0), .track1_i(track1), .img_mounted_i(img_mounted),
		.img_size_i(img_size), .sd_ack_i(sd_ack), .sd_buff_addr_i(sd_buff_addr),
		.sd_buff_dout_i(sd_buff_dout), .sd_buff_wr_i(sd_buff_wr),
		.fd_track_addr_i(fd_track_addr), .fd_write_i(fd_write), .fd_data_i(fd_data),
		.joy_i(joy), .kbd_rows_i(kbd_rows), .kbd_cols_i(kbd_cols),
		.sd_lba_o(sd_lba), .sd_rd_o(sd_rd), .sd_wr_o(sd_wr), .sd_buff_din_o(sd_buff_din),
		.fd_data_o(fd_rdata), .cpu_wait_o(cpu_wait), .led_o(led), .kbd_cols_o(kbd_merged)
	);

	sd_host_model host_inst (
		.CLK_VIDEO(CLK_VIDEO), .dd_reset(dd_reset), .sd_rd_i(sd_rd), .sd_wr_i(sd_wr),
		.sd_lba_i(sd_lba), .sd_buff_din_i(sd_buff_din), .sd_ack_o(sd_ack),
		.sd_buff_addr_o(sd_buff_addr), .sd_buff_dout_o(sd_buff_dout),
		.sd_buff_wr_o(sd_buff_wr)
	);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #20 CLK_VIDEO = ~CLK_VIDEO;
	end

	//==============================
	// Handshake assertions
	//==============================
	assign req_any = (|sd_rd) | (|sd_wr);

	// Rising acknowledges seen during one request
	always @(posedge CLK_VIDEO) begin
		ack_q <= |sd_ack;
		if (dd_reset || (!req_any && !(|sd_ack))) begin
			ack_count <= 0;
		end else if ((|sd_ack) && !ack_q) begin
			ack_count <= ack_count + 1;
		end
	end

	assert property (@(posedge CLK_VIDEO) disable iff (dd_reset)
		$fell(req_any) |-> (ack_count == 13))
	else begin
		$display("request released after %0d acknowledges instead of 13", ack_count);
		errors++;
	end

	assert property (@(posedge CLK_VIDEO) disable iff (dd_reset) req_any |-> cpu_wait)
	else begin
		$display("cpu_wait_o was low while an SD request was active");
		errors++;
	end

	task automatic check_hex(input string name, input logic [31:0] got,
	                         input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (cpu_wait !== level && n < limit && !timed_out) begin
			@(negedge CLK_VIDEO);
			n++;
		end
		if (cpu_wait !== level && !timed_out) begin
			$display("timeout: cpu_wait_o did not go to %0d while %s", level, what);
			timed_out = 1'b1;
		end
	endtask

	task automatic mount_drive(input int drive);
		img_size    = 32'h0004_0000;
		img_mounted = 2'(1 << drive);
		@(negedge CLK_VIDEO);
		img_mounted = 2'b00;
	endtask

	task automatic check_blocks(input int start, input int base, input logic drive,
	                            input logic is_wr);
		int i;
		for (i = 0; i < 13; i++) begin
			check_hex("sd_lba_o", host_inst.blk_lba[start + i], 32'(base + i));
			check_hex("sd drive", 32'(host_inst.blk_drv[start + i]), 32'(drive));
			check_hex("sd_wr_o", 32'(host_inst.blk_wr[start + i]), 32'(is_wr));
		end
	endtask

	task automatic check_reads(input logic drive, input int track, input int n);
		int i;
		int sec;
		int off;
		for (i = 0; i < n; i++) begin
			rng = xorshift32(rng);
			sec = int'(rng[7:0]) % 13;
			off = int'(rng[24:16]);
			fd_track_addr = {1'b0, 4'(sec), 9'(off)};
			@(negedge CLK_VIDEO);
			check_hex("fd_data_o", 32'(fd_rdata),
			          32'(image_byte(drive, 32'(track * 13 + sec), 9'(off))));
		end
	endtask

	task automatic finish_test(input int num, input string name);
		tests_run++;
		if (errors != err_at_start || timed_out) begin
			tests_failed++;
			$display("test %0d %s: failed", num, name);
		end else begin
			$display("test %0d %s: ok", num, name);
		end
		err_at_start = errors;
	endtask

	initial begin
		dd_reset      = 1'b1;
		fd_active     = 2'b00;
		track0        = 6'd0;
		track1        = 6'd0;
		img_mounted   = 2'b00;
		img_size      = 32'd0;
		fd_track_addr = 14'd0;
		fd_write      = 1'b0;
		fd_data       = 8'd0;
		joy           = 6'd0;
		kbd_rows      = 8'd0;
		kbd_cols      = 6'd0;
		errors        = 0;
		err_at_start  = 0;
		tests_run     = 0;
		tests_failed  = 0;
		timed_out     = 1'b0;
		rng           = RNG_SEED;
		repeat (8) @(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		dd_reset = 1'b0;
		@(negedge CLK_VIDEO);

		check_hex("sd_rd_o", 32'(sd_rd), 32'h0);
		check_hex("sd_wr_o", 32'(sd_wr), 32'h0);
		check_hex("cpu_wait_o", 32'(cpu_wait), 32'h0);
		check_hex("kbd_cols_o", 32'(kbd_merged), 32'h0);
		finish_test(1, "reset state");

		// First load of drive 0, track 0
		fd_active = 2'b01;
		first     = host_inst.blk_count;
		mount_drive(0);
		wait_busy(1'b1, 8, "starting the first load");
		wait_busy(1'b0, 20000, "loading track 0");
		if (!timed_out) begin
			check_hex("block count", 32'(host_inst.blk_count - first), 32'd13);
			check_blocks(first, 0, 1'b0, 1'b0);
			check_hex("led_o", 32'(led), 32'h1);
			check_reads(1'b0, 0, 16);
		end
		finish_test(2, "mount and load track 0");

		if (!timed_out) begin
			first  = host_inst.blk_count;
			track0 = 6'd5;
			wait_busy(1'b1, 8, "starting the track 5 load");
			wait_busy(1'b0, 20000, "loading track 5");
			check_hex("block count", 32'(host_inst.blk_count - first), 32'd13);
			check_blocks(first, 65, 1'b0, 1'b0);
			check_reads(1'b0, 5, 16);
			finish_test(3, "move to track 5");
		end

		//==============================
		// Dirty track flush
		//==============================
		if (!timed_out) begin
			for (int i = 0; i < 8; i++) begin
				rng       = xorshift32(rng);
				wr_off[i] = int'(rng[8:0]);
				wr_val[i] = rng[23:16];
				fd_track_addr = {1'b0, 4'(i), 9'(wr_off[i])};
				fd_data       = wr_val[i];
				fd_write      = 1'b1;
				@(negedge CLK_VIDEO);
			end
			fd_write = 1'b0;
			first    = host_inst.blk_count;
			track0   = 6'd6;
			wait_busy(1'b1, 8, "starting the flush");
			wait_busy(1'b0, 40000, "flushing track 5 and loading track 6");
			check_hex("block count", 32'(host_inst.blk_count - first), 32'd26);
			check_blocks(first, 65, 1'b0, 1'b1);
			check_blocks(first + 13, 78, 1'b0, 1'b0);
			for (int i = 0; i < 8; i++) begin
				check_hex("sd_buff_din_o", 32'(host_inst.wr_mem[(65 + i) * 512 + wr_off[i]]),
				          32'(wr_val[i]));
			end
			check_hex("sd_buff_din_o", 32'(host_inst.wr_mem[77 * 512 + 300]),
			          32'(image_byte(1'b0, 32'd77, 9'd300)));
			check_reads(1'b0, 6, 16);
			finish_test(4, "flush dirty track 5, load track 6");
		end

		if (!timed_out) begin
			first  = host_inst.blk_count;
			track1 = 6'd3;
			mount_drive(1);
			wait_busy(1'b1, 8, "starting the drive 1 load");
			wait_busy(1'b0, 20000, "loading drive 1 track 3");
			check_hex("block count", 32'(host_inst.blk_count - first), 32'd13);
			check_blocks(first, 39, 1'b1, 1'b0);
			fd_active = 2'b10;
			check_reads(1'b1, 3, 16);
			fd_active = 2'b00;
			@(negedge CLK_VIDEO);
			check_hex("fd_data_o", 32'(fd_rdata), 32'h0);
			check_hex("led_o", 32'(led), 32'h0);
			finish_test(5, "drive 1 select");
		end

		//==============================
		// Joystick merge
		//==============================
		if (!timed_out) begin
			for (int i = 0; i < 64; i++) begin
				rng      = xorshift32(rng);
				kbd_rows = rng[7:0];
				kbd_cols = rng[13:8];
				joy      = rng[21:16];
				// Arrows in column 0, fire 1 row 7 column 4, fire 2 row 1 column 5
				exp_cols    = kbd_cols;
				exp_cols[0] = exp_cols[0] | (kbd_rows[6] & joy[3]) | (kbd_rows[5] & joy[2]) |
				              (kbd_rows[4] & joy[0]) | (kbd_rows[3] & joy[1]);
				exp_cols[4] = exp_cols[4] | (kbd_rows[7] & joy[4]);
				exp_cols[5] = exp_cols[5] | (kbd_rows[1] & joy[5]);
				@(negedge CLK_VIDEO);
				check_hex("kbd_cols_o", 32'(kbd_merged), 32'(exp_cols));
			end
			finish_test(6, "joystick merge");
		end

		$display("tests run %0d, tests failed %0d, failed checks %0d",
		         tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog/joy_key_merge.sv
//==============================
// Joystick to key matrix merge
//==============================

`timescale 1ns/1ns

module joy_key_merge (
	input  logic       CLK_VIDEO,
	input  logic       dd_reset,
	input  logic [5:0] joy_i,
	input  logic [7:0] kbd_rows_i,
	input  logic [5:0] kbd_cols_i,
	output logic [5:0] kbd_cols_o
);
	import tk_disk_pkg::*;

	logic       dir_hit;
	logic [5:0] inject;

	// Arrow keys share one column, each on its own row
	assign dir_hit = (kbd_rows_i[ROW_UP]    & joy_i[JOY_UP])    |
	                 (kbd_rows_i[ROW_DOWN]  & joy_i[JOY_DOWN])  |
	                 (kbd_rows_i[ROW_RIGHT] & joy_i[JOY_RIGHT]) |
	                 (kbd_rows_i[ROW_LEFT]  & joy_i[JOY_LEFT]);

	always_comb begin
		inject            = '0;
		inject[COL_ARROW] = dir_hit;
		inject[COL_FIRE1] = kbd_rows_i[ROW_FIRE1] & joy_i[JOY_FIRE1];
		inject[COL_FIRE2] = kbd_rows_i[ROW_FIRE2] & joy_i[JOY_FIRE2];
	end

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			kbd_cols_o <= '0;
		end else begin
			kbd_cols_o <= kbd_cols_i | inject;
		end
	end

endmodule

//--- verilog/sd_block_counter.sv
//==============================
// SD block counter
// Block address and sector index
// stepped by acknowledge edges
//==============================

`timescale 1ns/1ns

module sd_block_counter (
	input  logic                 CLK_VIDEO,
	input  logic                 dd_reset,
	input  logic                 sd_ack_served_i,
	sd_xfer_if.cnt               xfer,
	output tk_disk_pkg::lba_t    sd_lba_o,
	output tk_disk_pkg::sector_t sector_o
);
	import tk_disk_pkg::*;

	logic ack_q;
	logic ack_rise;
	logic ack_fall;
	logic last;

	assign ack_rise = sd_ack_served_i & ~ack_q;
	assign ack_fall = ~sd_ack_served_i & ack_q;
	assign last     = (xfer.sector == sector_t'(LAST_SECTOR));

	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			ack_q         <= 1'b0;
			xfer.lba      <= '0;
			xfer.sector   <= '0;
			xfer.req_drop <= 1'b0;
			xfer.done     <= 1'b0;
		end else begin
			ack_q     <= sd_ack_served_i;
			xfer.done <= 1'b0;
			if (xfer.start) begin
				xfer.lba      <= xfer.base_lba;
				xfer.sector   <= '0;
				xfer.req_drop <= 1'b0;
			end else begin
				// Host has taken the block, point at the next one
				if (ack_rise) begin
					xfer.lba <= xfer.lba + 1'b1;
					if (last) begin
						xfer.req_drop <= 1'b1;
					end
				end
				if (ack_fall) begin
					xfer.sector <= xfer.sector + 1'b1;
					xfer.done   <= last;
				end
			end
		end
	end

	assign sd_lba_o = xfer.lba;
	assign sector_o = xfer.sector;

endmodule

//--- verilog/sd_xfer_if.sv
//==============================
// Transfer control between the
// track sequencer and the SD
// block counter
//==============================

`timescale 1ns/1ns

interface sd_xfer_if;
	import tk_disk_pkg::*;

	// Sequencer side
	logic    start;
	lba_t    base_lba;
	logic    is_write;

	// Counter side
	lba_t    lba;
	sector_t sector;
	logic    done;
	logic    req_drop;

	modport seq (
		output start, base_lba, is_write,
		input  lba, sector, done, req_drop
	);

	modport cnt (
		input  start, base_lba,
		output lba, sector, done, req_drop
	);

endinterface

//--- verilog/tk_disk_pkg.sv
//==============================
// Disk geometry and track sizes
// Shared data types
// Sequencer state codes
// Joystick and key matrix bits
//==============================

package tk_disk_pkg;

	// Disk geometry
	localparam int SECTORS_PER_TRACK = 13;
	localparam int LAST_SECTOR       = 12;
	localparam int SECTOR_BYTES_LOG2 = 9;
	localparam int NUM_DRIVES        = 2;

	typedef logic [5:0]                              track_t;
	typedef logic [3:0]                              sector_t;
	typedef logic [13:0]                             track_addr_t;
	typedef logic [31:0]                             lba_t;
	typedef logic [7:0]                              byte_t;
	typedef logic [NUM_DRIVES-1:0]                   drive_mask_t;

	// Track sequencer states
	localparam logic [2:0] ST_IDLE     = 3'd0;
	localparam logic [2:0] ST_WR_START = 3'd1;
	localparam logic [2:0] ST_WR_WAIT  = 3'd2;
	localparam logic [2:0] ST_RD_START = 3'd3;
	localparam logic [2:0] ST_RD_WAIT  = 3'd4;

	// Joystick word, active high
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	// Matrix rows and column bits
	localparam int ROW_FIRE2 = 1;
	localparam int ROW_LEFT  = 3;
	localparam int ROW_RIGHT = 4;
	localparam int ROW_DOWN  = 5;
	localparam int ROW_UP    = 6;
	localparam int ROW_FIRE1 = 7;
	localparam int COL_ARROW = 0;
	localparam int COL_FIRE1 = 4;
	localparam int COL_FIRE2 = 5;

endpackage

//--- verilog/tk_disk_top.sv
//==============================
// Floppy track cache top level
// Sequencer, block counter, two
// track buffers, joystick merge
//==============================

`timescale 1ns/1ns

module tk_disk_top (
	input  logic                                      CLK_VIDEO,
	input  logic                                      dd_reset,
	input  tk_disk_pkg::drive_mask_t                  fd_active_i,
	input  tk_disk_pkg::track_t                       track0_i,
	input  tk_disk_pkg::track_t                       track1_i,
	input  tk_disk_pkg::drive_mask_t                  img_mounted_i,
	input  logic [31:0]                               img_size_i,
	input  tk_disk_pkg::drive_mask_t                  sd_ack_i,
	input  logic [tk_disk_pkg::SECTOR_BYTES_LOG2-1:0] sd_buff_addr_i,
	input  tk_disk_pkg::byte_t                        sd_buff_dout_i,
	input  logic                                      sd_buff_wr_i,
	input  tk_disk_pkg::track_addr_t                  fd_track_addr_i,
	input  logic                                      fd_write_i,
	input  tk_disk_pkg::byte_t                        fd_data_i,
	input  logic [5:0]                                joy_i,
	input  logic [7:0]                                kbd_rows_i,
	input  logic [5:0]                                kbd_cols_i,
	output tk_disk_pkg::lba_t                         sd_lba_o,
	output tk_disk_pkg::drive_mask_t                  sd_rd_o,
	output tk_disk_pkg::drive_mask_t                  sd_wr_o,
	output tk_disk_pkg::byte_t                        sd_buff_din_o,
	output tk_disk_pkg::byte_t                        fd_data_o,
	output logic                                      cpu_wait_o,
	output logic                                      led_o,
	output logic [5:0]                                kbd_cols_o
);
	import tk_disk_pkg::*;

	sd_xfer_if   xfer_if ();

	logic        sd_ack_served;
	sector_t     sector;
	track_addr_t sd_addr;
	drive_mask_t sd_we;
	drive_mask_t fd_we;
	byte_t       buf_rdata0;
	byte_t       buf_rdata1;
	byte_t       fd_rdata0;
	byte_t       fd_rdata1;

	// Sector index above the byte offset from the host
	assign sd_addr = {1'b0, sector, sd_buff_addr_i};

	track_sequencer track_sequencer_inst (
		.CLK_VIDEO       (CLK_VIDEO),
		.dd_reset        (dd_reset),
		.fd_active_i     (fd_active_i),
		.track0_i        (track0_i),
		.track1_i        (track1_i),
		.img_mounted_i   (img_mounted_i),
		.img_size_i      (img_size_i),
		.sd_ack_i        (sd_ack_i),
		.sd_buff_wr_i    (sd_buff_wr_i),
		.fd_write_i      (fd_write_i),
		.xfer            (xfer_if.seq),
		.buf_rdata0_i    (buf_rdata0),
		.buf_rdata1_i    (buf_rdata1),
		.fd_rdata0_i     (fd_rdata0),
		.fd_rdata1_i     (fd_rdata1),
		.sd_rd_o         (sd_rd_o),
		.sd_wr_o         (sd_wr_o),
		.sd_ack_served_o (sd_ack_served),
		.sd_we_o         (sd_we),
		.sd_buff_din_o   (sd_buff_din_o),
		.fd_we_o         (fd_we),
		.fd_data_o       (fd_data_o),
		.cpu_wait_o      (cpu_wait_o),
		.led_o           (led_o)
	);

	sd_block_counter sd_block_counter_inst (
		.CLK_VIDEO       (CLK_VIDEO),
		.dd_reset        (dd_reset),
		.sd_ack_served_i (sd_ack_served),
		.xfer            (xfer_if.cnt),
		.sd_lba_o        (sd_lba_o),
		.sector_o        (sector)
	);

	//==============================
	// One buffer per drive
	//==============================
	track_buffer track_buffer_0 (
		.CLK_VIDEO  (CLK_VIDEO),
		.sd_addr_i  (sd_addr),
		.sd_we_i    (sd_we[0]),
		.sd_wdata_i (sd_buff_dout_i),
		.sd_rdata_o (buf_rdata0),
		.fd_addr_i  (fd_track_addr_i),
		.fd_we_i    (fd_we[0]),
		.fd_wdata_i (fd_data_i),
		.fd_rdata_o (fd_rdata0)
	);

	track_buffer track_buffer_1 (
		.CLK_VIDEO  (CLK_VIDEO),
		.sd_addr_i  (sd_addr),
		.sd_we_i    (sd_we[1]),
		.sd_wdata_i (sd_buff_dout_i),
		.sd_rdata_o (buf_rdata1),
		.fd_addr_i  (fd_track_addr_i),
		.fd_we_i    (fd_we[1]),
		.fd_wdata_i (fd_data_i),
		.fd_rdata_o (fd_rdata1)
	);

	joy_key_merge joy_key_merge_inst (
		.CLK_VIDEO  (CLK_VIDEO),
		.dd_reset   (dd_reset),
		.joy_i      (joy_i),
		.kbd_rows_i (kbd_rows_i),
		.kbd_cols_i (kbd_cols_i),
		.kbd_cols_o (kbd_cols_o)
	);

endmodule

//--- verilog/track_buffer.sv
//==============================
// Track buffer
// 16K dual-port byte memory
//==============================

`timescale 1ns/1ns

module track_buffer (
	input  logic                     CLK_VIDEO,
	input  tk_disk_pkg::track_addr_t sd_addr_i,
	input  logic                     sd_we_i,
	input  tk_disk_pkg::byte_t       sd_wdata_i,
	output tk_disk_pkg::byte_t       sd_rdata_o,
	input  tk_disk_pkg::track_addr_t fd_addr_i,
	input  logic                     fd_we_i,
	input  tk_disk_pkg::byte_t       fd_wdata_i,
	output tk_disk_pkg::byte_t       fd_rdata_o
);
	import tk_disk_pkg::*;

	byte_t mem [2**$bits(track_addr_t)];

	// SD host side
	always_ff @(posedge CLK_VIDEO) begin
		if (sd_we_i) begin
			mem[sd_addr_i] <= sd_wdata_i;
		end
		sd_rdata_o <= mem[sd_addr_i];
	end

	// Disk controller side
	always_ff @(posedge CLK_VIDEO) begin
		if (fd_we_i) begin
			mem[fd_addr_i] <= fd_wdata_i;
		end
		fd_rdata_o <= mem[fd_addr_i];
	end

endmodule

//--- verilog/track_sequencer.sv
//==============================
// Track sequencer
// Mount, track change and dirty
// tracking per drive, plus the
// flush and load FSM
//==============================

`timescale 1ns/1ns

module track_sequencer (
	input  logic                     CLK_VIDEO,
	input  logic                     dd_reset,
	input  tk_disk_pkg::drive_mask_t fd_active_i,
	input  tk_disk_pkg::track_t      track0_i,
	input  tk_disk_pkg::track_t      track1_i,
	input  tk_disk_pkg::drive_mask_t img_mounted_i,
	input  logic [31:0]              img_size_i,
	input  tk_disk_pkg::drive_mask_t sd_ack_i,
	input  logic                     sd_buff_wr_i,
	input  logic                     fd_write_i,
	sd_xfer_if.seq                   xfer,
	input  tk_disk_pkg::byte_t       buf_rdata0_i,
	input  tk_disk_pkg::byte_t       buf_rdata1_i,
	input  tk_disk_pkg::byte_t       fd_rdata0_i,
	input  tk_disk_pkg::byte_t       fd_rdata1_i,
	output tk_disk_pkg::drive_mask_t sd_rd_o,
	output tk_disk_pkg::drive_mask_t sd_wr_o,
	output logic                     sd_ack_served_o,
	output tk_disk_pkg::drive_mask_t sd_we_o,
	output tk_disk_pkg::byte_t       sd_buff_din_o,
	output tk_disk_pkg::drive_mask_t fd_we_o,
	output tk_disk_pkg::byte_t       fd_data_o,
	output logic                     cpu_wait_o,
	output logic                     led_o
);
	import tk_disk_pkg::*;

	logic [2:0]  state;
	logic        srv;
	logic        pick;
	logic        req_on;
	drive_mask_t srv_mask;
	drive_mask_t mounted;
	drive_mask_t fresh;
	drive_mask_t dirty;
	drive_mask_t need;
	track_t      head_trk [NUM_DRIVES];
	track_t      loaded_trk [NUM_DRIVES];
	track_t      lba_trk;

	assign head_trk[0] = track0_i;
	assign head_trk[1] = track1_i;

	// A drive needs a load on a new image or when its head has moved
	always_comb begin
		for (int d = 0; d < NUM_DRIVES; d++) begin
			need[d] = fresh[d] | (mounted[d] & (head_trk[d] != loaded_trk[d]));
		end
	end

	// Drive 0 goes first
	assign pick = ~need[0];

	//==============================
	// Flush and load FSM
	//==============================
	always_ff @(posedge CLK_VIDEO) begin
		if (dd_reset) begin
			state   <= ST_IDLE;
			srv     <= 1'b0;
			mounted <= '0;
			fresh   <= '0;
			dirty   <= '0;
			for (int d = 0; d < NUM_DRIVES; d++) begin
				loaded_trk[d] <= '0;
			end
		end else begin
			case (state)
				ST_IDLE: begin
					if (|need) begin
						srv         <= pick;
						fresh[pick] <= 1'b0;
						if (dirty[pick]) begin
							dirty[pick] <= 1'b0;
							state       <= ST_WR_START;
						end else begin
							state <= ST_RD_START;
						end
					end
				end
				ST_WR_START: state <= ST_WR_WAIT;
				ST_WR_WAIT: begin
					if (xfer.done) begin
						state <= ST_RD_START;
					end
				end
				ST_RD_START: begin
					loaded_trk[srv] <= head_trk[srv];
					state           <= ST_RD_WAIT;
				end
				ST_RD_WAIT: begin
					if (xfer.done) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase

			// A mount pulse overrides whatever the FSM cleared above
			for (int d = 0; d < NUM_DRIVES; d++) begin
				if (img_mounted_i[d]) begin
					mounted[d] <= |img_size_i;
					fresh[d]   <= |img_size_i;
					dirty[d]   <= 1'b0;
				end else if (fd_we_o[d]) begin
					dirty[d] <= 1'b1;
				end
			end
		end
	end

	// Counter control
	assign xfer.start    = (state == ST_WR_START) | (state == ST_RD_START);
	assign xfer.is_write = (state == ST_WR_START) | (state == ST_WR_WAIT);
	// Flush goes to the old track, read to the new one
	assign lba_trk       = xfer.is_write ? loaded_trk[srv] : head_trk[srv];
	assign xfer.base_lba = lba_t'(lba_trk) * lba_t'(SECTORS_PER_TRACK);

	// SD request, released once the last block is acknowledged
	assign req_on   = ((state == ST_WR_WAIT) | (state == ST_RD_WAIT)) & ~xfer.req_drop;
	assign srv_mask = drive_mask_t'(1) << srv;
	assign sd_rd_o  = srv_mask & {NUM_DRIVES{req_on & ~xfer.is_write}};
	assign sd_wr_o  = srv_mask & {NUM_DRIVES{req_on & xfer.is_write}};
	assign sd_ack_served_o = sd_ack_i[srv];

	// Buffer enables and read muxes
	assign sd_we_o       = srv_mask & sd_ack_i & {NUM_DRIVES{sd_buff_wr_i}};
	assign sd_buff_din_o = srv ? buf_rdata1_i : buf_rdata0_i;
	assign fd_we_o       = {fd_active_i[1] & ~fd_active_i[0], fd_active_i[0]} &
	                       {NUM_DRIVES{fd_write_i}};
	assign fd_data_o     = fd_active_i[0] ? fd_rdata0_i :
	                       fd_active_i[1] ? fd_rdata1_i : '0;

	assign cpu_wait_o = (state != ST_IDLE);
	assign led_o      = |fd_active_i;

endmodule
